/* Bender.yml */
package:
  name: route_node

sources:
  - rtl/route_pkg.sv
  - rtl/mem_port_if.sv
  - rtl/learn_costs.sv
  - rtl/find_best_hop.sv
  - rtl/winner_policy.sv
  - rtl/mem_arbiter.sv
  - rtl/route_node.sv
  - target: test
    files:
      - tb/route_node_tb.sv

/* route_node.f */
rtl/route_pkg.sv
rtl/mem_port_if.sv
rtl/learn_costs.sv
rtl/find_best_hop.sv
rtl/winner_policy.sv
rtl/mem_arbiter.sv
rtl/route_node.sv
tb/route_node_tb.sv

/* rtl/find_best_hop.sv */
`timescale 1ns/1ps
`default_nettype none

module find_best_hop #(
	parameter route_pkg::word_t BATTERY_MIN = 16'h2000
) (
	input wire clock,
	input wire nrst,
	input wire start,
	mem_port_if.requester mem,
	output logic [5:0] best_index,
	output logic best_valid,
	output route_pkg::word_t nbr_count,
	output logic done
);

	typedef enum logic [2:0] {
		B_IDLE, B_CNT_REQ, B_CNT_RD, B_BAT_REQ, B_BAT_RD, B_Q_REQ, B_Q_RD, B_DONE
	} state_t;

	state_t state;
	logic [5:0] idx;
	logic battery_ok;
	logic scan_last;
	route_pkg::word_t best_q;

	assign scan_last = (route_pkg::word_t'(idx) + 16'd1 >= nbr_count) ||
		(idx == 6'(route_pkg::TABLE_SLOTS - 1));

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= B_IDLE;
			idx <= '0;
			best_valid <= 1'b0;
			nbr_count <= '0;
		end else begin
			case (state)
				B_IDLE: begin
					if (start) begin
						best_valid <= 1'b0;
						state <= B_CNT_REQ;
					end
				end
				B_CNT_REQ: state <= B_CNT_RD;
				B_CNT_RD: begin
					nbr_count <= mem.rdata;
					idx <= '0;
					state <= (mem.rdata == '0) ? B_DONE : B_BAT_REQ;
				end
				B_BAT_REQ: state <= B_BAT_RD;
				B_BAT_RD: begin
					battery_ok <= (mem.rdata >= BATTERY_MIN);
					state <= B_Q_REQ;
				end
				B_Q_REQ: state <= B_Q_RD;
				B_Q_RD: begin
					// strict compare, so a tie keeps the lower index
					if (battery_ok && (!best_valid || mem.rdata < best_q)) begin
						best_q <= mem.rdata;
						best_index <= idx;
						best_valid <= 1'b1;
					end
					if (scan_last) begin
						state <= B_DONE;
					end else begin
						idx <= idx + 6'd1;
						state <= B_BAT_REQ;
					end
				end
				B_DONE: state <= B_IDLE;
				default: state <= B_IDLE;
			endcase
		end
	end

	always_comb begin
		case (state)
			B_BAT_REQ: mem.address = route_pkg::NBR_BATTERY_BASE + route_pkg::addr_t'(idx);
			B_Q_REQ: mem.address = route_pkg::NBR_Q_BASE + route_pkg::addr_t'(idx);
			default: mem.address = route_pkg::NBR_COUNT_ADDR;
		endcase
	end

	// read only
	assign mem.wr_en = 1'b0;
	assign mem.wdata = '0;
	assign done = (state == B_DONE);

endmodule

`default_nettype wire

/* rtl/learn_costs.sv */
`timescale 1ns/1ps
`default_nettype none

module learn_costs #(
	parameter route_pkg::word_t MY_NODE_ID = 16'd3,
	parameter int MAX_NEIGHBORS = 64
) (
	input wire clock,
	input wire nrst,
	input wire start,
	input wire route_pkg::word_t src_id,
	input wire route_pkg::word_t src_battery,
	input wire route_pkg::word_t src_value,
	input wire route_pkg::word_t src_cluster,
	mem_port_if.requester mem,
	output logic done
);

	typedef enum logic [2:0] {
		L_IDLE, L_CNT_REQ, L_CNT_RD, L_ID_REQ, L_ID_RD, L_MISS, L_WRITE, L_DONE
	} state_t;

	state_t state;
	logic [5:0] idx;
	logic [2:0] wstep;
	logic append;
	logic scan_last;
	route_pkg::word_t count;
	route_pkg::word_t pkt_id, pkt_battery, pkt_value, pkt_cluster;
	route_pkg::addr_t slot;

	assign slot = route_pkg::addr_t'(idx);
	// last stored entry, or the end of the table
	assign scan_last = (route_pkg::word_t'(idx) + 16'd1 >= count) ||
		(idx == 6'(route_pkg::TABLE_SLOTS - 1));

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= L_IDLE;
			idx <= '0;
			wstep <= '0;
			append <= 1'b0;
		end else begin
			case (state)
				L_IDLE: begin
					if (start) begin
						pkt_id <= src_id;
						pkt_battery <= src_battery;
						pkt_value <= src_value;
						pkt_cluster <= src_cluster;
						// own echo, nothing to learn
						state <= (src_id == MY_NODE_ID) ? L_DONE : L_CNT_REQ;
					end
				end
				L_CNT_REQ: state <= L_CNT_RD;
				L_CNT_RD: begin
					count <= mem.rdata;
					idx <= '0;
					state <= (mem.rdata == '0) ? L_MISS : L_ID_REQ;
				end
				L_ID_REQ: state <= L_ID_RD;
				L_ID_RD: begin
					if (mem.rdata == pkt_id) begin
						append <= 1'b0;
						wstep <= '0;
						state <= L_WRITE;
					end else if (scan_last) begin
						state <= L_MISS;
					end else begin
						idx <= idx + 6'd1;
						state <= L_ID_REQ;
					end
				end
				L_MISS: begin
					// new neighbor goes in the first free slot
					if (count < MAX_NEIGHBORS) begin
						idx <= count[5:0];
						append <= 1'b1;
						wstep <= '0;
						state <= L_WRITE;
					end else begin
						state <= L_DONE;
					end
				end
				L_WRITE: begin
					if (wstep == (append ? 3'd4 : 3'd2))
						state <= L_DONE;
					else
						wstep <= wstep + 3'd1;
				end
				L_DONE: state <= L_IDLE;
				default: state <= L_IDLE;
			endcase
		end
	end

	// write order: cluster, battery, Q, then ID and count on append
	always_comb begin
		mem.address = route_pkg::NBR_COUNT_ADDR;
		mem.wdata = '0;
		case (state)
			L_ID_REQ: mem.address = route_pkg::NBR_ID_BASE + slot;
			L_WRITE: begin
				case (wstep)
					3'd0: begin
						mem.address = route_pkg::NBR_CLUSTER_BASE + slot;
						mem.wdata = pkt_cluster;
					end
					3'd1: begin
						mem.address = route_pkg::NBR_BATTERY_BASE + slot;
						mem.wdata = pkt_battery;
					end
					3'd2: begin
						mem.address = route_pkg::NBR_Q_BASE + slot;
						mem.wdata = pkt_value;
					end
					3'd3: begin
						mem.address = route_pkg::NBR_ID_BASE + slot;
						mem.wdata = pkt_id;
					end
					default: mem.wdata = count + 16'd1;
				endcase
			end
			default: ;
		endcase
	end

	assign mem.wr_en = (state == L_WRITE);
	assign done = (state == L_DONE);

endmodule

`default_nettype wire

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input wire clock,
	input wire nrst,
	input wire done_learn,
	input wire done_best,
	input wire done_reward,
	mem_port_if.grant learn_port,
	mem_port_if.grant best_port,
	mem_port_if.grant policy_port,
	output route_pkg::addr_t address,
	output logic wr_en,
	output route_pkg::word_t mem_data_in,
	input wire route_pkg::word_t mem_data_out,
	output logic learn_ready
);

	route_pkg::phase_t phase;

	// only the active phase's done moves the owner on
	always_ff @(posedge clock) begin
		if (!nrst) begin
			phase <= route_pkg::PHASE_LEARN;
		end else begin
			case (phase)
				route_pkg::PHASE_LEARN: if (done_learn) phase <= route_pkg::PHASE_BEST;
				route_pkg::PHASE_BEST: if (done_best) phase <= route_pkg::PHASE_POLICY;
				route_pkg::PHASE_POLICY: if (done_reward) phase <= route_pkg::PHASE_LEARN;
				default: phase <= route_pkg::PHASE_LEARN;
			endcase
		end
	end

	always_comb begin
		case (phase)
			route_pkg::PHASE_LEARN: begin
				address = learn_port.address;
				wr_en = learn_port.wr_en;
				mem_data_in = learn_port.wdata;
			end
			route_pkg::PHASE_BEST: begin
				address = best_port.address;
				wr_en = best_port.wr_en;
				mem_data_in = best_port.wdata;
			end
			route_pkg::PHASE_POLICY: begin
				address = policy_port.address;
				wr_en = policy_port.wr_en;
				mem_data_in = policy_port.wdata;
			end
			default: begin
				address = '0;
				wr_en = 1'b0;
				mem_data_in = '0;
			end
		endcase
	end

	assign learn_port.rdata = mem_data_out;
	assign best_port.rdata = mem_data_out;
	assign policy_port.rdata = mem_data_out;

	// a new packet is taken only while no later phase owns memory
	assign learn_ready = (phase == route_pkg::PHASE_LEARN);

endmodule

`default_nettype wire

/* rtl/mem_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one word-wide memory port between a phase and the arbiter
interface mem_port_if;

	route_pkg::addr_t address;
	logic wr_en;
	route_pkg::word_t wdata;
	// read data, one cycle after the address
	route_pkg::word_t rdata;

	modport requester (
		output address,
		output wr_en,
		output wdata,
		input rdata
	);

	modport grant (
		input address,
		input wr_en,
		input wdata,
		output rdata
	);

endinterface

`default_nettype wire

/* rtl/route_node.sv */
`timescale 1ns/1ps
`default_nettype none

module route_node #(
	parameter route_pkg::word_t MY_NODE_ID = 16'd3,
	parameter route_pkg::word_t MY_CLUSTER_ID = 16'd1,
	parameter int EPSILON = 32,
	parameter route_pkg::word_t BATTERY_MIN = 16'h2000,
	parameter int MAX_NEIGHBORS = 64
) (
	input wire clock,
	input wire nrst,
	input wire en,
	input wire route_pkg::word_t src_id,
	input wire route_pkg::word_t src_battery,
	input wire route_pkg::word_t src_value,
	input wire route_pkg::word_t src_cluster,
	input wire route_pkg::word_t mem_data_out,
	output route_pkg::addr_t address,
	output logic wr_en,
	output route_pkg::word_t mem_data_in,
	output route_pkg::word_t next_hop,
	output route_pkg::word_t reward_out,
	output logic done_reward
);

	logic done_learn;
	logic done_best;
	logic learn_ready;
	logic best_valid;
	logic [5:0] best_index;
	route_pkg::word_t nbr_count;

	mem_port_if learn_port ();
	mem_port_if best_port ();
	mem_port_if policy_port ();

	learn_costs #(
		.MY_NODE_ID(MY_NODE_ID),
		.MAX_NEIGHBORS(MAX_NEIGHBORS)
	) u_learn_costs (
		.clock(clock),
		.nrst(nrst),
		.start(en && learn_ready),
		.src_id(src_id),
		.src_battery(src_battery),
		.src_value(src_value),
		.src_cluster(src_cluster),
		.mem(learn_port.requester),
		.done(done_learn)
	);

	find_best_hop #(
		.BATTERY_MIN(BATTERY_MIN)
	) u_find_best_hop (
		.clock(clock),
		.nrst(nrst),
		.start(done_learn),
		.mem(best_port.requester),
		.best_index(best_index),
		.best_valid(best_valid),
		.nbr_count(nbr_count),
		.done(done_best)
	);

	winner_policy #(
		.MY_CLUSTER_ID(MY_CLUSTER_ID),
		.EPSILON(EPSILON)
	) u_winner_policy (
		.clock(clock),
		.nrst(nrst),
		.start(done_best),
		.best_index(best_index),
		.best_valid(best_valid),
		.nbr_count(nbr_count),
		.mem(policy_port.requester),
		.next_hop(next_hop),
		.reward_out(reward_out),
		.done(done_reward)
	);

	mem_arbiter u_mem_arbiter (
		.clock(clock),
		.nrst(nrst),
		.done_learn(done_learn),
		.done_best(done_best),
		.done_reward(done_reward),
		.learn_port(learn_port.grant),
		.best_port(best_port.grant),
		.policy_port(policy_port.grant),
		.address(address),
		.wr_en(wr_en),
		.mem_data_in(mem_data_in),
		.mem_data_out(mem_data_out),
		.learn_ready(learn_ready)
	);

endmodule

`default_nettype wire

/* rtl/route_pkg.sv */
`default_nettype none

package route_pkg;

	// one memory word, used for IDs, battery levels and Q values
	typedef logic [15:0] word_t;
	typedef logic [10:0] addr_t;

	// neighbor table columns, entry i at base + i
	localparam addr_t NBR_ID_BASE = 11'h048;
	localparam addr_t NBR_CLUSTER_BASE = 11'h0C8;
	localparam addr_t NBR_BATTERY_BASE = 11'h148;
	localparam addr_t NBR_Q_BASE = 11'h1C8;

	// number of known neighbors
	localparam addr_t NBR_COUNT_ADDR = 11'h68A;

	localparam int TABLE_SLOTS = 64;

	// reward terms
	localparam word_t HOP_COST = 16'd1;
	localparam word_t CLUSTER_PENALTY = 16'd16;

	// lfsr state after reset, must be nonzero
	localparam word_t LFSR_SEED = 16'hACE1;

	// owner of the external memory port
	typedef enum logic [1:0] {
		PHASE_LEARN,
		PHASE_BEST,
		PHASE_POLICY
	} phase_t;

endpackage

`default_nettype wire

/* rtl/winner_policy.sv */
`timescale 1ns/1ps
`default_nettype none

module winner_policy #(
	parameter route_pkg::word_t MY_CLUSTER_ID = 16'd1,
	parameter int EPSILON = 32
) (
	input wire clock,
	input wire nrst,
	input wire start,
	input wire [5:0] best_index,
	input wire best_valid,
	input wire route_pkg::word_t nbr_count,
	mem_port_if.requester mem,
	output route_pkg::word_t next_hop,
	output route_pkg::word_t reward_out,
	output logic done
);

	typedef enum logic [2:0] {
		P_IDLE, P_MOD, P_RD_ID, P_RD_Q, P_RD_CL, P_FINISH, P_DONE
	} state_t;

	state_t state;
	logic [15:0] lfsr;
	logic [15:0] lfsr_next;
	logic feedback;
	logic explore;
	route_pkg::word_t rem;
	route_pkg::word_t hop_id;
	route_pkg::word_t hop_q;
	route_pkg::word_t penalty;
	route_pkg::addr_t slot;

	// fibonacci lfsr, taps 16 14 13 11
	assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
	assign lfsr_next = {lfsr[14:0], feedback};

	// decided on the stepped value
	assign explore = (int'(lfsr_next[7:0]) < EPSILON) || !best_valid;

	// rem is below the count once the reads start
	assign slot = route_pkg::addr_t'(rem);

	// in P_FINISH the read data is the chosen entry's cluster
	assign penalty = (mem.rdata != MY_CLUSTER_ID) ? route_pkg::CLUSTER_PENALTY : 16'd0;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= P_IDLE;
			lfsr <= route_pkg::LFSR_SEED;
			next_hop <= '0;
			reward_out <= '0;
		end else begin
			case (state)
				P_IDLE: begin
					if (start) begin
						lfsr <= lfsr_next;
						rem <= explore ? route_pkg::word_t'(lfsr_next[13:8]) :
							route_pkg::word_t'(best_index);
						if (nbr_count == '0) begin
							next_hop <= '0;
							reward_out <= '0;
							state <= P_DONE;
						end else begin
							state <= P_MOD;
						end
					end
				end
				// remainder by repeated subtraction
				P_MOD: begin
					if (rem >= nbr_count)
						rem <= rem - nbr_count;
					else
						state <= P_RD_ID;
				end
				P_RD_ID: state <= P_RD_Q;
				P_RD_Q: begin
					hop_id <= mem.rdata;
					state <= P_RD_CL;
				end
				P_RD_CL: begin
					hop_q <= mem.rdata;
					state <= P_FINISH;
				end
				P_FINISH: begin
					next_hop <= hop_id;
					reward_out <= hop_q + route_pkg::HOP_COST + penalty;
					state <= P_DONE;
				end
				P_DONE: state <= P_IDLE;
				default: state <= P_IDLE;
			endcase
		end
	end

	// back-to-back reads of ID, Q and cluster
	always_comb begin
		case (state)
			P_RD_ID: mem.address = route_pkg::NBR_ID_BASE + slot;
			P_RD_Q: mem.address = route_pkg::NBR_Q_BASE + slot;
			P_RD_CL: mem.address = route_pkg::NBR_CLUSTER_BASE + slot;
			default: mem.address = route_pkg::NBR_COUNT_ADDR;
		endcase
	end

	assign mem.wr_en = 1'b0;
	assign mem.wdata = '0;
	assign done = (state == P_DONE);

endmodule

`default_nettype wire

/* tb/route_node_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module route_node_tb;

	localparam int ROWS = 13;
	localparam int WAIT_LIMIT = 300;
	localparam time PERIOD = 100;
	localparam route_pkg::word_t MY_NODE_ID = 16'd3;
	localparam route_pkg::word_t MY_CLUSTER_ID = 16'd1;
	localparam int EPSILON = 32;
	localparam route_pkg::word_t BATTERY_MIN = 16'h2000;

	logic clock;
	logic nrst;
	logic en;
	route_pkg::word_t src_id, src_battery, src_value, src_cluster;
	route_pkg::word_t mem_data_out;
	route_pkg::addr_t address;
	logic wr_en;
	route_pkg::word_t mem_data_in, next_hop, reward_out;
	logic done_reward;

	// each row holds id, battery, value, cluster, stray strobe and expected count
	logic [95:0] packets [0:ROWS-1];
	route_pkg::word_t mem_model [0:2047];
	int writes_total;
	int errors;
	int checks;
	int explored;

	// reference model of the neighbor table and the lfsr
	route_pkg::word_t m_id [0:63];
	route_pkg::word_t m_cluster [0:63];
	route_pkg::word_t m_battery [0:63];
	route_pkg::word_t m_q [0:63];
	int m_count;
	logic [15:0] m_lfsr;

	route_node #(
		.MY_NODE_ID(MY_NODE_ID),
		.MY_CLUSTER_ID(MY_CLUSTER_ID),
		.EPSILON(EPSILON),
		.BATTERY_MIN(BATTERY_MIN),
		.MAX_NEIGHBORS(64)
	) u_route_node (
		.clock(clock),
		.nrst(nrst),
		.en(en),
		.src_id(src_id),
		.src_battery(src_battery),
		.src_value(src_value),
		.src_cluster(src_cluster),
		.mem_data_out(mem_data_out),
		.address(address),
		.wr_en(wr_en),
		.mem_data_in(mem_data_in),
		.next_hop(next_hop),
		.reward_out(reward_out),
		.done_reward(done_reward)
	);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// word memory that returns read data one cycle after the address
	always @(posedge clock) begin
		if (wr_en === 1'b1) begin
			mem_model[address] <= mem_data_in;
			writes_total <= writes_total + 1;
		end
		mem_data_out <= #1 mem_model[address];
	end

	task compare_word(input string name, input route_pkg::word_t got,
		input route_pkg::word_t expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("** Error: %s = %h, expected %h", name, got, expected);
		end
	endtask

	function automatic logic [15:0] lfsr_step(input logic [15:0] value);
		// taps 16 14 13 11 with the new bit entering at bit 0
		return {value[14:0], value[15] ^ value[13] ^ value[12] ^ value[10]};
	endfunction

	// id 99 never shows up in the table, so an accepted stray packet leaves a trace
	task automatic send_stray();
		en = 1'b1;
		src_id = 16'd99;
		src_battery = 16'hFFFF;
		src_value = 16'd0;
		@(posedge clock);
		#1 en = 1'b0;
	endtask

	task automatic update_ref_table(input route_pkg::word_t id, input route_pkg::word_t bat,
		input route_pkg::word_t val, input route_pkg::word_t cl, output int writes);
		int hit;
		hit = -1;
		writes = 0;
		if (id != MY_NODE_ID) begin
			for (int i = 0; i < m_count; i++)
				if (hit < 0 && m_id[i] == id)
					hit = i;
			if (hit >= 0 || m_count < 64) begin
				writes = (hit < 0) ? 5 : 3;
				if (hit < 0) begin
					hit = m_count;
					m_id[hit] = id;
					m_count++;
				end
				m_cluster[hit] = cl;
				m_battery[hit] = bat;
				m_q[hit] = val;
			end
		end
	endtask

	task automatic predict_hop(output route_pkg::word_t hop, output route_pkg::word_t reward);
		int best;
		int pick;
		best = -1;
		hop = '0;
		reward = '0;
		for (int i = 0; i < m_count; i++)
			if (m_battery[i] >= BATTERY_MIN && (best < 0 || m_q[i] < m_q[best]))
				best = i;
		m_lfsr = lfsr_step(m_lfsr);
		if (m_count > 0) begin
			if (best < 0 || int'(m_lfsr[7:0]) < EPSILON) begin
				pick = int'(m_lfsr[13:8]) % m_count;
				explored++;
			end else begin
				pick = best;
			end
			hop = m_id[pick];
			reward = m_q[pick] + route_pkg::HOP_COST;
			// hop out of this node's cluster
			if (m_cluster[pick] != MY_CLUSTER_ID)
				reward = reward + route_pkg::CLUSTER_PENALTY;
		end
	endtask

	task automatic verify_table();
		for (int i = 0; i < m_count; i++) begin
			compare_word($sformatf("id[%0d]", i), mem_model[route_pkg::NBR_ID_BASE + i], m_id[i]);
			compare_word($sformatf("cluster[%0d]", i),
				mem_model[route_pkg::NBR_CLUSTER_BASE + i], m_cluster[i]);
			compare_word($sformatf("battery[%0d]", i),
				mem_model[route_pkg::NBR_BATTERY_BASE + i], m_battery[i]);
			compare_word($sformatf("q[%0d]", i), mem_model[route_pkg::NBR_Q_BASE + i], m_q[i]);
		end
	endtask

	initial begin
		route_pkg::word_t r_id, r_bat, r_val, r_cl, r_busy, r_cnt;
		route_pkg::word_t hop, reward;
		int writes;
		int writes_before;
		int cycles;
		errors = 0;
		checks = 0;
		explored = 0;
		writes_total = 0;
		nrst = 1'b0;
		en = 1'b0;
		src_id = '0;
		src_battery = '0;
		src_value = '0;
		src_cluster = '0;
		mem_data_out = '0;
		m_count = 0;
		m_lfsr = route_pkg::LFSR_SEED;
		for (int i = 0; i < 2048; i++)
			mem_model[i] = '0;
		// own echo on an empty table, appends, a tie, updates, low batteries
		// stray strobe 1 lands while learning and 2 in the done cycle
		packets[0] = {16'd3, 16'h4000, 16'd7, 16'd1, 16'd0, 16'd0};
		packets[1] = {16'd10, 16'h1000, 16'd50, 16'd1, 16'd0, 16'd1};
		packets[2] = {16'd11, 16'h1800, 16'd40, 16'd2, 16'd0, 16'd2};
		packets[3] = {16'd12, 16'h8000, 16'd30, 16'd1, 16'd0, 16'd3};
		packets[4] = {16'd13, 16'h9000, 16'd20, 16'd2, 16'd0, 16'd4};
		packets[5] = {16'd14, 16'hA000, 16'd20, 16'd1, 16'd0, 16'd5};
		packets[6] = {16'd3, 16'h9000, 16'd1, 16'd1, 16'd0, 16'd5};
		packets[7] = {16'd12, 16'h8000, 16'd5, 16'd1, 16'd0, 16'd5};
		packets[8] = {16'd15, 16'h0100, 16'd1, 16'd1, 16'd0, 16'd6};
		packets[9] = {16'd16, 16'h2000, 16'd9, 16'd3, 16'd2, 16'd7};
		packets[10] = {16'd13, 16'h9000, 16'd2, 16'd2, 16'd0, 16'd7};
		packets[11] = {16'd17, 16'h3000, 16'd60, 16'd1, 16'd0, 16'd8};
		packets[12] = {16'd11, 16'h2500, 16'd4, 16'd2, 16'd1, 16'd8};

		repeat (8) @(posedge clock);
		#1 nrst = 1'b1;
		@(posedge clock);
		#1;
		compare_word("done_reward", {15'd0, done_reward}, 16'd0);
		compare_word("wr_en", {15'd0, wr_en}, 16'd0);
		compare_word("next_hop", next_hop, 16'd0);
		compare_word("reward_out", reward_out, 16'd0);

		for (int row = 0; row < ROWS; row++) begin
			{r_id, r_bat, r_val, r_cl, r_busy, r_cnt} = packets[row];
			writes_before = writes_total;
			en = 1'b1;
			src_id = r_id;
			src_battery = r_bat;
			src_value = r_val;
			src_cluster = r_cl;
			@(posedge clock);
			#1 en = 1'b0;
			if (r_busy == 16'd1) begin
				// learn_costs is still reading the table
				repeat (2) @(posedge clock);
				#1;
				send_stray();
			end
			cycles = 0;
			while (done_reward !== 1'b1 && cycles < WAIT_LIMIT) begin
				@(posedge clock);
				#1;
				cycles++;
			end
			if (done_reward !== 1'b1) begin
				errors++;
				$display("row %0d: no done_reward within %0d cycles", row, WAIT_LIMIT);
			end else begin
				update_ref_table(r_id, r_bat, r_val, r_cl, writes);
				predict_hop(hop, reward);
				compare_word($sformatf("writes row %0d", row),
					route_pkg::word_t'(writes_total - writes_before), route_pkg::word_t'(writes));
				compare_word("count word", mem_model[route_pkg::NBR_COUNT_ADDR], r_cnt);
				verify_table();
				compare_word($sformatf("next_hop row %0d", row), next_hop, hop);
				compare_word($sformatf("reward_out row %0d", row), reward_out, reward);
			end
			// arbiter is back on learn one cycle after done_reward
			if (r_busy == 16'd2 && done_reward === 1'b1) begin
				// the policy phase still owns memory at this edge
				send_stray();
			end else begin
				@(posedge clock);
				#1;
			end
		end

		$display("explored rows: %0d, checks: %0d, errors: %0d", explored, checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		repeat (ROWS * 400) @(posedge clock);
		$display("timed out: the run did not finish within %0d cycles", ROWS * 400);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
